// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= phaethonCoreTb
RTL_TOP   ?= phaethonCore
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+src
+incdir+tb
src/phaethonPkg.sv
src/sequencer.sv
src/registerFile.sv
src/memAddressUnit.sv
src/executeUnit.sv
src/phaethonCore.sv
tb/phaethonCoreTb.sv

// ==== src/executeUnit.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "phaethonCore_config.svh"

module executeUnit import phaethonPkg::*; (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       execute,
  input  logic [`OPCODE_WIDTH-1:0]   opCode,
  input  logic [`REG_ADDR_WIDTH-1:0] regA,
  input  cpuWord_u                   dataWord,
  input  cpuWord_u                   loadData,
  input  cpuWord_u                   readA,
  input  cpuWord_u                   readB,
  input  cpuWord_u                   readC,
  output logic                       wrEn,
  output logic                       spInc,
  output logic                       spDec,
  output logic [`REG_ADDR_WIDTH-1:0] wrAddr,
  output cpuWord_u                   wrData,
  output cpuWord_u                   dout,
  output logic                       doutValid
);

  cpuWord_u cmpRhs;
  cpuWord_u flagWord;

  // Flag compare, register A against B or the constant
  assign cmpRhs = (opCode == `OP_CMP_RC) ? dataWord : readB;

  always_comb begin
    flagWord               = '0;
    flagWord.flags.equal   = readA.data == cmpRhs.data;
    flagWord.flags.less    = readA.data < cmpRhs.data;   // Unsigned
    flagWord.flags.greater = readA.data > cmpRhs.data;
  end

  // Writeback select
  always_comb begin
    wrEn   = 1'b0;
    wrAddr = regA;      // Destination is field A for nearly all
    wrData = dataWord;
    spInc  = 1'b0;
    spDec  = 1'b0;
    if (execute) begin
      wrEn = 1'b1;
      case (opCode)
        `OP_MOV_RC:  wrData = dataWord;
        `OP_MOV_RR:  wrData = readB;
        `OP_LD_RC, `OP_LD_RR, `OP_LD_RRC: wrData = loadData;
        `OP_POP_R: begin
          wrData = loadData;
          spDec  = 1'b1;
        end
        `OP_PUSH_R, `OP_CALL_R: begin
          wrEn  = 1'b0;
          spInc = 1'b1;
        end
        `OP_RET: begin
          wrEn  = 1'b0;
          spDec = 1'b1;
        end
        `OP_ADD_RRR: wrData.data = readB.data + readC.data;
        `OP_ADD_RRC: wrData.data = readB.data + dataWord.data;
        `OP_SUB_RRR: wrData.data = readB.data - readC.data;
        `OP_SUB_RRC: wrData.data = readB.data - dataWord.data;
        `OP_INC_R:   wrData.data = readA.data + 1;
        `OP_DEC_R:   wrData.data = readA.data - 1;
        `OP_SHL_RRR: wrData.data = readB.data << readC.data;  // Zero past 31
        `OP_SHR_RRR: wrData.data = readB.data >> readC.data;
        `OP_NEG_RR:  wrData.data = -readB.data;
        `OP_CMP_RR, `OP_CMP_RC: begin
          wrAddr = `FLAG_REG;
          wrData = flagWord;
        end
        // Three-register compares give 0 or 1
        `OP_CMPE_RRR:  wrData.data = `WORD_WIDTH'(readB.data == readC.data);
        `OP_CMPNE_RRR: wrData.data = `WORD_WIDTH'(readB.data != readC.data);
        `OP_CMPLT_RRR: wrData.data = `WORD_WIDTH'(readB.data < readC.data);
        `OP_CMPGT_RRR: wrData.data = `WORD_WIDTH'(readB.data > readC.data);
        default: wrEn = 1'b0;  // Stores, jumps, dout, stall
      endcase
    end
  end

  // Debug output, one pulse per dout instruction
  always_ff @(posedge clk) begin
    if (!rstN) begin
      doutValid <= 1'b0;
    end else begin
      doutValid <= execute && opCode == `OP_DOUT_R;
    end
    if (execute && opCode == `OP_DOUT_R) dout <= readA;  // Held until next dout
  end

endmodule

`default_nettype wire

// ==== src/memAddressUnit.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "phaethonCore_config.svh"

module memAddressUnit import phaethonPkg::*; (
  input  logic [`OPCODE_WIDTH-1:0] opCode,
  input  cpuWord_u                 dataWord,
  input  cpuWord_u                 readA,
  input  cpuWord_u                 readB,
  input  cpuWord_u                 readC,
  input  cpuWord_u                 spOut,
  input  cpuWord_u                 ipointer,
  output cpuWord_u                 memAddr,
  output cpuWord_u                 memWdata,
  output logic                     memRead,
  output logic                     memWrite
);

  always_comb begin
    // Bus words are don't care unless a request is raised
    memAddr  = readC;
    memWdata = readB;
    memRead  = 1'b0;
    memWrite = 1'b0;
    case (opCode)
      `OP_LD_RC: begin
        memAddr = dataWord;
        memRead = 1'b1;
      end
      `OP_LD_RR: begin
        memAddr = readB;
        memRead = 1'b1;
      end
      `OP_LD_RRC: begin
        memAddr.data = readB.data + dataWord.data;  // Base plus offset
        memRead      = 1'b1;
      end
      `OP_ST_CR: begin
        memAddr  = dataWord;
        memWrite = 1'b1;
      end
      `OP_ST_RCR: begin
        memAddr.data = readA.data + dataWord.data;
        memWrite     = 1'b1;
      end
      `OP_PUSH_R: begin
        memAddr  = spOut;   // SP points at next free slot
        memWdata = readA;
        memWrite = 1'b1;
      end
      `OP_CALL_R: begin
        memAddr  = spOut;
        memWdata = ipointer;  // Return address is call site
        memWrite = 1'b1;
      end
      `OP_POP_R, `OP_RET: begin
        memAddr.data = spOut.data - `STACK_STEP;  // Top of stack
        memRead      = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/phaethonCore.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "phaethonCore_config.svh"

module phaethonCore import phaethonPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  cpuWord_u ramIn,
  output cpuWord_u ramAddress,
  output cpuWord_u ramOut,      // Store data, straight from address unit
  output logic     readReq,
  output logic     writeReq,
  output cpuWord_u ipointer,
  output cpuWord_u dout,
  output logic     doutValid
);

  // Decoded instruction
  logic [`OPCODE_WIDTH-1:0]   opCode;
  logic [`REG_ADDR_WIDTH-1:0] regA;
  logic [`REG_ADDR_WIDTH-1:0] regB;
  logic [`REG_ADDR_WIDTH-1:0] regC;
  cpuWord_u                   dataWord;
  cpuWord_u                   loadData;
  logic                       execute;

  // Register file reads
  cpuWord_u readA;
  cpuWord_u readB;
  cpuWord_u readC;
  cpuWord_u flags;
  cpuWord_u spOut;

  // Memory request from address unit
  cpuWord_u memAddr;
  logic     memRead;
  logic     memWrite;

  // Writeback
  logic                       wrEn;
  logic [`REG_ADDR_WIDTH-1:0] wrAddr;
  cpuWord_u                   wrData;
  logic                       spInc;
  logic                       spDec;

  sequencer seq (
    .clk(clk), .rstN(rstN), .ramIn(ramIn),
    .readA(readA), .readB(readB), .readC(readC), .flags(flags),
    .memAddr(memAddr), .memWdata(ramOut), .memRead(memRead), .memWrite(memWrite),
    .ramAddress(ramAddress), .readReq(readReq), .writeReq(writeReq),
    .opCode(opCode), .regA(regA), .regB(regB), .regC(regC),
    .dataWord(dataWord), .loadData(loadData), .execute(execute), .ipointer(ipointer)
  );

  registerFile regs (
    .clk(clk), .regA(regA), .regB(regB), .regC(regC),
    .readA(readA), .readB(readB), .readC(readC), .flags(flags), .spOut(spOut),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData), .spInc(spInc), .spDec(spDec)
  );

  memAddressUnit mau (
    .opCode(opCode), .dataWord(dataWord), .readA(readA), .readB(readB), .readC(readC),
    .spOut(spOut), .ipointer(ipointer),
    .memAddr(memAddr), .memWdata(ramOut), .memRead(memRead), .memWrite(memWrite)
  );

  executeUnit exu (
    .clk(clk), .rstN(rstN), .execute(execute), .opCode(opCode), .regA(regA),
    .dataWord(dataWord), .loadData(loadData), .readA(readA), .readB(readB), .readC(readC),
    .wrEn(wrEn), .spInc(spInc), .spDec(spDec), .wrAddr(wrAddr), .wrData(wrData),
    .dout(dout), .doutValid(doutValid)
  );

endmodule

`default_nettype wire

// ==== src/phaethonCore_config.svh ====
`ifndef PHAETHON_CORE_CONFIG_SVH
`define PHAETHON_CORE_CONFIG_SVH

// Datapath and register file sizing
`define WORD_WIDTH      32
`define OPCODE_WIDTH    8
`define REG_COUNT       64
`define REG_ADDR_WIDTH  6
`define INSTR_BYTES     4      // One instruction word
`define STACK_STEP      4      // Stack grows upward in bytes
`define SP_REG          0
`define FLAG_REG        1

// Register fields, low 6 bits taken from each byte
`define FIELD_A_LSB     8
`define FIELD_B_LSB     16
`define FIELD_C_LSB     24

// Opcodes at or above this carry a second data word
`define LONG_OPCODE_MIN 8'h80

// Short opcodes
`define OP_MOV_RR       8'h01
`define OP_LD_RR        8'h02
`define OP_PUSH_R       8'h03
`define OP_POP_R        8'h04
`define OP_CALL_R       8'h05
`define OP_RET          8'h06
`define OP_ADD_RRR      8'h10
`define OP_SUB_RRR      8'h11
`define OP_INC_R        8'h12
`define OP_DEC_R        8'h13
`define OP_SHL_RRR      8'h14
`define OP_SHR_RRR      8'h15
`define OP_NEG_RR       8'h16
`define OP_CMP_RR       8'h20
`define OP_CMPE_RRR     8'h21
`define OP_CMPNE_RRR    8'h22
`define OP_CMPLT_RRR    8'h23
`define OP_CMPGT_RRR    8'h24
`define OP_DOUT_R       8'h30
`define OP_STALL        8'h31

// Long opcodes
`define OP_MOV_RC       8'h80
`define OP_LD_RC        8'h81
`define OP_LD_RRC       8'h82
`define OP_ST_CR        8'h83
`define OP_ST_RCR       8'h84
`define OP_ADD_RRC      8'h90
`define OP_SUB_RRC      8'h91
`define OP_CMP_RC       8'hA0
`define OP_JMP_C        8'hB0
`define OP_JE_C         8'hB1
`define OP_JNE_C        8'hB2
`define OP_JZ_RC        8'hB3
`define OP_JNZ_RC       8'hB4

`endif

// ==== src/phaethonPkg.sv ====
`default_nettype none
`include "phaethonCore_config.svh"

package phaethonPkg;

  // One machine word, read as data or as compare flags (register 1)
  typedef union packed {
    logic [`WORD_WIDTH-1:0] data;
    struct packed {
      logic [`WORD_WIDTH-4:0] unused;
      logic                   greater;
      logic                   less;
      logic                   equal;    // Bit 0
    } flags;
  } cpuWord_u;

endpackage

`default_nettype wire

// ==== src/registerFile.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "phaethonCore_config.svh"

module registerFile import phaethonPkg::*; (
  input  logic                       clk,
  input  logic [`REG_ADDR_WIDTH-1:0] regA,
  input  logic [`REG_ADDR_WIDTH-1:0] regB,
  input  logic [`REG_ADDR_WIDTH-1:0] regC,
  output cpuWord_u                   readA,
  output cpuWord_u                   readB,
  output cpuWord_u                   readC,
  output cpuWord_u                   flags,
  output cpuWord_u                   spOut,
  input  logic                       wrEn,
  input  logic [`REG_ADDR_WIDTH-1:0] wrAddr,
  input  cpuWord_u                   wrData,
  input  logic                       spInc,
  input  logic                       spDec
);

  cpuWord_u regs [`REG_COUNT];

  // Combinational reads
  assign readA = regs[regA];
  assign readB = regs[regB];
  assign readC = regs[regC];
  assign flags = regs[`FLAG_REG];  // Compare result
  assign spOut = regs[`SP_REG];

  always_ff @(posedge clk) begin
    if (wrEn) regs[wrAddr] <= wrData;
    // Push and call grow the stack, pop and return shrink it
    if (spInc) begin
      regs[`SP_REG].data <= regs[`SP_REG].data + `STACK_STEP;
    end else if (spDec) begin
      regs[`SP_REG].data <= regs[`SP_REG].data - `STACK_STEP;
    end
  end

endmodule

`default_nettype wire

// ==== src/sequencer.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "phaethonCore_config.svh"

module sequencer import phaethonPkg::*; (
  input  logic                       clk,
  input  logic                       rstN,
  input  cpuWord_u                   ramIn,
  input  cpuWord_u                   readA,
  input  cpuWord_u                   readB,
  input  cpuWord_u                   readC,
  input  cpuWord_u                   flags,
  input  cpuWord_u                   memAddr,
  input  cpuWord_u                   memWdata,
  input  logic                       memRead,
  input  logic                       memWrite,
  output cpuWord_u                   ramAddress,
  output logic                       readReq,
  output logic                       writeReq,
  output logic [`OPCODE_WIDTH-1:0]   opCode,
  output logic [`REG_ADDR_WIDTH-1:0] regA,
  output logic [`REG_ADDR_WIDTH-1:0] regB,
  output logic [`REG_ADDR_WIDTH-1:0] regC,
  output cpuWord_u                   dataWord,
  output cpuWord_u                   loadData,
  output logic                       execute,
  output cpuWord_u                   ipointer
);

  // Mode sequence, one step per clock
  localparam logic [3:0] MODE_INITIAL    = 4'd0;
  localparam logic [3:0] MODE_INSTR_WAIT = 4'd1;
  localparam logic [3:0] MODE_INSTR_DONE = 4'd2;
  localparam logic [3:0] MODE_REG_SET    = 4'd3;
  localparam logic [3:0] MODE_DATA_WAIT  = 4'd4;
  localparam logic [3:0] MODE_DATA_DONE  = 4'd5;
  localparam logic [3:0] MODE_MEM_REQ    = 4'd6;
  localparam logic [3:0] MODE_MEM_WAIT   = 4'd7;
  localparam logic [3:0] MODE_MEM_DONE   = 4'd8;
  localparam logic [3:0] MODE_PROCESS    = 4'd9;

  logic [3:0] mode;
  logic       isLong;
  logic       needsMem;
  logic       condTaken;

  assign isLong   = opCode >= `LONG_OPCODE_MIN;  // Encoding puts 8-byte forms on top
  assign needsMem = memRead | memWrite;
  assign execute  = mode == MODE_PROCESS;         // Writeback strobe

  // Branch condition, operands stable until end of Process
  always_comb begin
    case (opCode)
      `OP_JE_C:  condTaken = flags.flags.equal;
      `OP_JNE_C: condTaken = !flags.flags.equal;
      `OP_JZ_RC: condTaken = readC.data == '0;
      `OP_JNZ_RC: condTaken = readC.data != '0;
      default:   condTaken = 1'b0;
    endcase
  end

  // Mode FSM, request pulses and instruction pointer
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mode     <= MODE_INITIAL;
      readReq  <= 1'b0;
      writeReq <= 1'b0;
      ipointer <= '0;
    end else begin
      case (mode)
        MODE_INITIAL: begin
          readReq <= 1'b1;                // Instruction fetch
          mode    <= MODE_INSTR_WAIT;
        end
        MODE_INSTR_WAIT: begin
          readReq <= 1'b0;
          mode    <= MODE_INSTR_DONE;
        end
        MODE_INSTR_DONE: mode <= MODE_REG_SET;
        MODE_REG_SET: begin
          if (isLong) begin
            readReq <= 1'b1;              // Data word fetch
            mode    <= MODE_DATA_WAIT;
          end else if (needsMem) begin
            mode <= MODE_MEM_REQ;
          end else begin
            mode <= MODE_PROCESS;
          end
        end
        MODE_DATA_WAIT: begin
          readReq <= 1'b0;
          mode    <= MODE_DATA_DONE;
        end
        MODE_DATA_DONE: mode <= needsMem ? MODE_MEM_REQ : MODE_PROCESS;
        MODE_MEM_REQ: begin
          readReq  <= memRead;
          writeReq <= memWrite;
          mode     <= MODE_MEM_WAIT;
        end
        MODE_MEM_WAIT: begin
          readReq  <= 1'b0;
          writeReq <= 1'b0;
          mode     <= MODE_MEM_DONE;
        end
        MODE_MEM_DONE: mode <= MODE_PROCESS;
        MODE_PROCESS: begin
          if (opCode == `OP_JMP_C) begin
            ipointer <= dataWord;
          end else if (opCode == `OP_CALL_R) begin
            ipointer <= readA;
          end else if (opCode == `OP_RET) begin
            ipointer.data <= loadData.data + `INSTR_BYTES;  // Skip the call
          end else if (condTaken) begin
            ipointer <= dataWord;
          end else if (opCode != `OP_STALL) begin
            ipointer.data <= ipointer.data + (isLong ? 2 * `INSTR_BYTES : `INSTR_BYTES);
          end
          mode <= MODE_INITIAL;
        end
        default: mode <= MODE_INITIAL;
      endcase
    end
  end

  // Instruction latch, bus address and captured words
  always_ff @(posedge clk) begin
    case (mode)
      MODE_INITIAL: ramAddress <= ipointer;
      MODE_INSTR_DONE: begin
        opCode <= ramIn.data[`OPCODE_WIDTH-1:0];
        regA   <= ramIn.data[`FIELD_A_LSB +: `REG_ADDR_WIDTH];  // Modulo 64
        regB   <= ramIn.data[`FIELD_B_LSB +: `REG_ADDR_WIDTH];
        regC   <= ramIn.data[`FIELD_C_LSB +: `REG_ADDR_WIDTH];
      end
      MODE_REG_SET: begin
        ramAddress.data <= ipointer.data + `INSTR_BYTES;
        dataWord        <= readB;  // Short forms see register B here
      end
      MODE_DATA_DONE: dataWord <= ramIn;
      MODE_MEM_REQ:   ramAddress <= memAddr;
      // Read data, or the word just stored
      MODE_MEM_DONE:  loadData <= memRead ? ramIn : memWdata;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== tb/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Bus event kinds, in the order the core issues them
localparam int EV_FETCH = 0;
localparam int EV_DATA  = 1;
localparam int EV_LOAD  = 2;
localparam int EV_STORE = 3;
localparam int EV_DOUT  = 4;

typedef struct {
  int       kind;
  cpuWord_u addr;
  cpuWord_u data;
  int       gap;    // Cycles since previous fetch, 0 to skip
} busEvent_t;

cpuWord_u  mReg [`REG_COUNT];
cpuWord_u  mMem [logic [31:0]];
busEvent_t expQ [$];

// Unwritten RAM reads back a pattern of the whole address
function automatic logic [31:0] fillWord(logic [31:0] a);
  return {a[15:0], a[31:16]} ^ 32'h6C3A_91E5;
endfunction

function automatic cpuWord_u modelRead(logic [31:0] a);
  if (mMem.exists(a)) return mMem[a];
  return cpuWord_u'(fillWord(a));
endfunction

function automatic void addEvent(int kind, logic [31:0] addr, logic [31:0] data, int gap);
  busEvent_t ev;
  ev.kind      = kind;
  ev.addr.data = addr;
  ev.data.data = data;
  ev.gap       = gap;
  expQ.push_back(ev);
endfunction

// Steps the program from address 0 up to the stall, recording bus traffic
task automatic runModel(output logic [31:0] stallAt);
  logic [31:0] ip, nextIp, dw, ra, rb, rc, sp, addr, wd, ld, rhs;
  logic [7:0]  op;
  logic [5:0]  a, b, c;
  cpuWord_u    w, fl;
  logic        isLong, hasMem, isWrite;
  int          gap;
  ip  = '0;
  gap = 0;
  op  = '0;
  stallAt = '0;
  while (op != `OP_STALL) begin
    addEvent(EV_FETCH, ip, '0, gap);
    w  = modelRead(ip);
    op = w.data[7:0];
    a  = w.data[13:8];   // Fields modulo 64
    b  = w.data[21:16];
    c  = w.data[29:24];
    isLong = op >= `LONG_OPCODE_MIN;
    dw = '0;
    if (isLong) begin
      addEvent(EV_DATA, ip + 4, '0, 0);
      w  = modelRead(ip + 4);
      dw = w.data;
    end
    ra = mReg[a].data;
    rb = mReg[b].data;
    rc = mReg[c].data;
    sp = mReg[`SP_REG].data;
    hasMem  = 1'b1;
    isWrite = 1'b0;
    addr    = dw;
    wd      = rb;
    ld      = '0;
    case (op)
      `OP_LD_RC:  addr = dw;
      `OP_LD_RR:  addr = rb;
      `OP_LD_RRC: addr = rb + dw;
      `OP_ST_CR:  isWrite = 1'b1;
      `OP_ST_RCR: begin
        addr    = ra + dw;
        isWrite = 1'b1;
      end
      `OP_PUSH_R: begin
        addr    = sp;
        wd      = ra;
        isWrite = 1'b1;
      end
      `OP_CALL_R: begin
        addr    = sp;
        wd      = ip;   // Call site goes on the stack
        isWrite = 1'b1;
      end
      `OP_POP_R, `OP_RET: addr = sp - `STACK_STEP;
      default: hasMem = 1'b0;
    endcase
    if (hasMem && isWrite) begin
      addEvent(EV_STORE, addr, wd, 0);
      mMem[addr] = cpuWord_u'(wd);
    end else if (hasMem) begin
      addEvent(EV_LOAD, addr, '0, 0);
      w  = modelRead(addr);
      ld = w.data;
    end
    nextIp = ip + (isLong ? 32'd8 : 32'd4);
    rhs    = (op == `OP_CMP_RC) ? dw : rb;
    case (op)
      `OP_MOV_RC: mReg[a].data = dw;
      `OP_MOV_RR: mReg[a].data = rb;
      `OP_LD_RC, `OP_LD_RR, `OP_LD_RRC: mReg[a].data = ld;
      `OP_PUSH_R: mReg[`SP_REG].data = sp + `STACK_STEP;
      `OP_POP_R: begin
        mReg[a].data = ld;
        mReg[`SP_REG].data = sp - `STACK_STEP;
      end
      `OP_CALL_R: begin
        mReg[`SP_REG].data = sp + `STACK_STEP;
        nextIp = ra;
      end
      `OP_RET: begin
        mReg[`SP_REG].data = sp - `STACK_STEP;
        nextIp = ld + 4;
      end
      `OP_ADD_RRR: mReg[a].data = rb + rc;
      `OP_ADD_RRC: mReg[a].data = rb + dw;
      `OP_SUB_RRR: mReg[a].data = rb - rc;
      `OP_SUB_RRC: mReg[a].data = rb - dw;
      `OP_INC_R:   mReg[a].data = ra + 1;
      `OP_DEC_R:   mReg[a].data = ra - 1;
      `OP_SHL_RRR: mReg[a].data = rb << rc;
      `OP_SHR_RRR: mReg[a].data = rb >> rc;
      `OP_NEG_RR:  mReg[a].data = -rb;
      `OP_CMP_RR, `OP_CMP_RC: begin
        fl = '0;
        fl.flags.equal   = ra == rhs;
        fl.flags.less    = ra < rhs;   // Unsigned
        fl.flags.greater = ra > rhs;
        mReg[`FLAG_REG] = fl;
      end
      `OP_CMPE_RRR:  mReg[a].data = {31'b0, rb == rc};
      `OP_CMPNE_RRR: mReg[a].data = {31'b0, rb != rc};
      `OP_CMPLT_RRR: mReg[a].data = {31'b0, rb < rc};
      `OP_CMPGT_RRR: mReg[a].data = {31'b0, rb > rc};
      `OP_JMP_C: nextIp = dw;
      `OP_JE_C:  if (mReg[`FLAG_REG].flags.equal) nextIp = dw;
      `OP_JNE_C: if (!mReg[`FLAG_REG].flags.equal) nextIp = dw;
      `OP_JZ_RC:  if (rc == '0) nextIp = dw;
      `OP_JNZ_RC: if (rc != '0) nextIp = dw;
      `OP_DOUT_R: addEvent(EV_DOUT, '0, ra, 0);
      `OP_STALL:  nextIp = ip;
      default: ;
    endcase
    gap = 5 + (isLong ? 2 : 0) + (hasMem ? 3 : 0);
    stallAt = ip;
    ip = nextIp;
  end
endtask

`endif

// ==== tb/phaethonCoreTb.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "phaethonCore_config.svh"

module phaethonCoreTb import phaethonPkg::*; ();

  localparam int          NUM_TESTS  = 6;
  localparam int          PROG_ITEMS = 40;
  localparam int          MAX_INSTR  = 64 + PROG_ITEMS * 6 + 1;  // Prologue, items, stall
  localparam logic [31:0] DATA_BASE  = 32'h0000_4000;
  localparam logic [31:0] STACK_BASE = 32'h0000_8000;
  localparam int          TIMEOUT_NS = NUM_TESTS * MAX_INSTR * 10 * 8 + 4000;

  logic     clk;
  logic     rstN;
  cpuWord_u ramIn;
  cpuWord_u ramAddress;
  cpuWord_u ramOut;
  logic     readReq;
  logic     writeReq;
  cpuWord_u ipointer;
  cpuWord_u dout;
  logic     doutValid;

  cpuWord_u    ram  [logic [31:0]];   // DUT side RAM
  cpuWord_u    prog [logic [31:0]];   // Generated image
  logic [31:0] pc;
  logic [31:0] stallAt;
  string       testName;
  int          valueErrors = 0;
  int          otherErrors = 0;
  int          cycle = 0;
  int          lastFetch = 0;
  logic        active = 1'b0;
  logic        done = 1'b0;

  `include "isaModel.svh"

  phaethonCore uut (
    .clk(clk), .rstN(rstN), .ramIn(ramIn), .ramAddress(ramAddress), .ramOut(ramOut),
    .readReq(readReq), .writeReq(writeReq), .ipointer(ipointer),
    .dout(dout), .doutValid(doutValid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic checkWord(string name, cpuWord_u exp, cpuWord_u act);
    if (exp !== act) begin
      valueErrors++;
      $display("** Error [%s] %s: expected %h, actual %h", testName, name, exp.data, act.data);
    end
  endtask

  task automatic checkBit(string name, logic exp, logic act);
    if (exp !== act) begin
      valueErrors++;
      $display("** Error [%s] %s: expected %b, actual %b", testName, name, exp, act);
    end
  endtask

  task automatic checkCount(string name, int exp, int act);
    if (exp != act) begin
      valueErrors++;
      $display("** Error [%s] %s: expected %0d, actual %0d", testName, name, exp, act);
    end
  endtask

  // RAM model returns read data well before the core samples it
  always @(negedge clk) begin
    if (writeReq) ram[ramAddress.data] = ramOut;
    if (readReq) begin
      if (ram.exists(ramAddress.data)) ramIn = ram[ramAddress.data];
      else ramIn = cpuWord_u'(fillWord(ramAddress.data));
    end
  end

  // Bus monitor against the model's event list
  always @(negedge clk) begin
    busEvent_t ev;
    if (active && (readReq || writeReq || doutValid)) begin
      if (expQ.size() == 0) begin
        if (readReq && ramAddress.data == stallAt) begin
          done = 1'b1;   // Stall refetched
        end else begin
          otherErrors++;
          $display("[%s] Bus activity after the stall at cycle %0d", testName, cycle);
        end
      end else begin
        ev = expQ.pop_front();
        checkBit("readReq", ev.kind <= EV_LOAD, readReq);
        checkBit("writeReq", ev.kind == EV_STORE, writeReq);
        checkBit("doutValid", ev.kind == EV_DOUT, doutValid);
        if (ev.kind == EV_DOUT) checkWord("dout", ev.data, dout);
        else checkWord("ramAddress", ev.addr, ramAddress);
        if (ev.kind == EV_STORE) checkWord("ramOut", ev.data, ramOut);
        if (ev.kind == EV_FETCH) begin
          checkWord("ipointer", ev.addr, ipointer);
          if (ev.gap != 0) checkCount("cycles per instruction", ev.gap, cycle - lastFetch);
          lastFetch = cycle;
        end
      end
    end
  end

  function automatic cpuWord_u encode(logic [7:0] op, logic [5:0] a, logic [5:0] b,
                                      logic [5:0] c);
    cpuWord_u   w;
    logic [7:0] hi;
    hi     = 8'($urandom());   // Junk above each field
    w.data = {hi[7:6], c, hi[5:4], b, hi[3:2], a, op};
    return w;
  endfunction

  task automatic emit(logic [7:0] op, logic [5:0] a, logic [5:0] b, logic [5:0] c,
                      logic [31:0] dw);
    prog[pc] = encode(op, a, b, c);
    pc += 4;
    if (op >= `LONG_OPCODE_MIN) begin
      prog[pc] = cpuWord_u'(dw);
      pc += 4;
    end
  endtask

  // Destinations avoid SP, flags and the data pointer r2
  function automatic logic [5:0] dst();
    return 6'(3 + $urandom_range(60));
  endfunction

  function automatic logic [5:0] src();
    return 6'($urandom());
  endfunction

  function automatic logic [7:0] pickArith();
    case ($urandom_range(7))
      0: return `OP_ADD_RRR;
      1: return `OP_SUB_RRR;
      2: return `OP_SHL_RRR;
      3: return `OP_SHR_RRR;
      4: return `OP_CMPE_RRR;
      5: return `OP_CMPNE_RRR;
      6: return `OP_CMPLT_RRR;
      default: return `OP_CMPGT_RRR;
    endcase
  endfunction

  function automatic logic [7:0] pickOther();
    case ($urandom_range(6))
      0: return `OP_ADD_RRC;
      1: return `OP_SUB_RRC;
      2: return `OP_MOV_RC;
      3: return `OP_INC_R;
      4: return `OP_DEC_R;
      5: return `OP_NEG_RR;
      default: return `OP_MOV_RR;
    endcase
  endfunction

  task automatic genProgram();
    logic [31:0] patch, off, start;
    logic [5:0]  d, s;
    prog.delete();
    pc = '0;
    emit(`OP_MOV_RC, 6'd0, '0, '0, STACK_BASE);
    emit(`OP_MOV_RC, 6'd1, '0, '0, '0);
    emit(`OP_MOV_RC, 6'd2, '0, '0, DATA_BASE);
    for (int r = 3; r < `REG_COUNT; r++) begin
      emit(`OP_MOV_RC, 6'(r), '0, '0, ($urandom_range(3) == 0) ? 32'd0 : $urandom());
    end
    for (int i = 0; i < PROG_ITEMS; i++) begin
      d = dst();
      s = src();
      off = 4 * $urandom_range(63);
      case ($urandom_range(7))
        0: emit(pickArith(), d, src(), src(), '0);
        1: emit(pickOther(), d, src(), src(), $urandom());
        2: begin
          if ($urandom_range(1) == 1) begin
            emit(`OP_CMP_RR, s, ($urandom_range(1) == 1) ? s : src(), '0, '0);
          end else begin
            emit(`OP_CMP_RC, s, '0, '0, $urandom());
          end
          patch = pc + 4;
          emit(($urandom_range(1) == 1) ? `OP_JE_C : `OP_JNE_C, '0, '0, '0, '0);
          emit(`OP_DOUT_R, src(), '0, '0, '0);   // Skipped when taken
          prog[patch].data = pc;
        end
        3: begin
          patch = pc + 4;
          emit(($urandom_range(1) == 1) ? `OP_JZ_RC : `OP_JNZ_RC, '0, '0, src(), '0);
          emit(`OP_DOUT_R, src(), '0, '0, '0);
          prog[patch].data = pc;
        end
        4: begin
          patch = pc + 4;
          emit(`OP_JMP_C, '0, '0, '0, '0);
          emit(`OP_DOUT_R, src(), '0, '0, '0);
          prog[patch].data = pc;
        end
        5: begin
          if ($urandom_range(1) == 1) emit(`OP_ST_CR, '0, s, '0, DATA_BASE + off);
          else emit(`OP_ST_RCR, 6'd2, s, '0, off);
          case ($urandom_range(2))
            0: emit(`OP_LD_RC, d, '0, '0, DATA_BASE + off);
            1: emit(`OP_LD_RR, d, 6'd2, '0, '0);
            default: emit(`OP_LD_RRC, d, 6'd2, '0, off);
          endcase
        end
        6: begin
          emit(`OP_PUSH_R, s, '0, '0, '0);
          emit(pickArith(), dst(), src(), src(), '0);
          emit(`OP_POP_R, d, '0, '0, '0);
        end
        default: begin
          // Subroutine placed past a jump, so control only moves forward
          start = pc;
          emit(`OP_MOV_RC, d, '0, '0, start + 20);
          emit(`OP_CALL_R, d, '0, '0, '0);
          patch = pc + 4;
          emit(`OP_JMP_C, '0, '0, '0, '0);
          emit(`OP_DOUT_R, src(), '0, '0, '0);
          emit(`OP_RET, '0, '0, '0, '0);
          prog[patch].data = pc;
        end
      endcase
      if ($urandom_range(1) == 1 || i % 8 == 0) emit(`OP_DOUT_R, d, '0, '0, '0);
    end
    emit(`OP_STALL, '0, '0, '0, '0);
  endtask

  // Watchdog
  initial begin
    #(TIMEOUT_NS * 1ns);
    $display("Run did not finish within %0d ns, the core seems to hang", TIMEOUT_NS);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rstN  = 1'b0;
    ramIn = '0;
    void'($urandom(32'h0d559033));
    for (int t = 0; t < NUM_TESTS; t++) begin
      testName = $sformatf("program%0d", t);
      genProgram();
      ram  = prog;
      mMem = prog;
      expQ.delete();
      runModel(stallAt);
      done = 1'b0;
      @(negedge clk);
      rstN = 1'b0;
      repeat (4) @(negedge clk);
      checkBit("readReq in reset", 1'b0, readReq);
      checkBit("writeReq in reset", 1'b0, writeReq);
      checkBit("doutValid in reset", 1'b0, doutValid);
      checkWord("ipointer in reset", '0, ipointer);
      rstN = 1'b1;
      @(posedge clk);
      active = 1'b1;
      wait (done);
      @(posedge clk);
      active = 1'b0;
    end
    $display("Errors: %0d value mismatches, %0d other faults", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
